// ==== design/noncomp_pkg.sv ====
// ---------------------------------------------------------
// FP32 non-computational unit shared types
// Format constants, operand and status structs, opcode enums
// ---------------------------------------------------------
`default_nettype none

package noncomp_pkg;

  // ---------------------------------------------------------
  // Format constants
  // ---------------------------------------------------------
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;

  // One FP32 word split into its fields
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Canonical quiet NaN, positive with only the quiet bit set
  localparam fp_t CANON_QNAN = 32'h7fc00000;

  // Operation groups of the unit
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } op_e;

  // Rounding-mode field, reused here as the sub-operation select
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } roundmode_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot class mask, bit order follows the RISC-V fclass encoding
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Per-operand class flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // ---------------------------------------------------------
  // Request and response bundles
  // ---------------------------------------------------------
  typedef struct packed {
    fp_t        operand_a;
    fp_t        operand_b;
    roundmode_e rnd_mode;
    op_e        op;
    logic       op_mod;
  } noncomp_req_t;

  typedef struct packed {
    fp_t        result;
    status_t    status;
    logic       extension_bit;
    classmask_e class_mask;
    logic       is_class;
  } noncomp_rsp_t;

endpackage

`default_nettype wire

// ==== design/fp_classifier.sv ====
// ---------------------------------------------------------
// Operand classifier
// Class flags for both operands, class mask for operand A
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_classifier (
  input  noncomp_pkg::fp_t        operand_a_i,
  input  noncomp_pkg::fp_t        operand_b_i,
  output noncomp_pkg::fp_info_t   info_a_o,
  output noncomp_pkg::fp_info_t   info_b_o,
  output noncomp_pkg::classmask_e class_mask_o
);

  import noncomp_pkg::*;

  // Decode one operand from its exponent and mantissa fields
  function automatic fp_info_t classify_operand(fp_t value);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero = (value.exponent == '0);
    exp_ones = (value.exponent == '1);
    man_zero = (value.mantissa == '0);
    info.is_normal    = ~exp_zero & ~exp_ones;
    info.is_subnormal = exp_zero & ~man_zero;
    info.is_zero      = exp_zero & man_zero;
    info.is_inf       = exp_ones & man_zero;
    info.is_nan       = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB, clear means signalling
    info.is_signalling = info.is_nan & ~value.mantissa[MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = classify_operand(operand_a_i);
  assign info_b_o = classify_operand(operand_b_i);

  // Class mask of operand A, sign picks the half of the mask
  always_comb begin
    if (info_a_o.is_normal) begin
      class_mask_o = operand_a_i.sign ? NEGNORM : POSNORM;
    end else if (info_a_o.is_subnormal) begin
      class_mask_o = operand_a_i.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_o.is_zero) begin
      class_mask_o = operand_a_i.sign ? NEGZERO : POSZERO;
    end else if (info_a_o.is_inf) begin
      class_mask_o = operand_a_i.sign ? NEGINF : POSINF;
    end else begin
      // Only NaNs remain here
      class_mask_o = info_a_o.is_signalling ? SNAN : QNAN;
    end
  end

endmodule

`default_nettype wire

// ==== design/fp_sign_inject.sv ====
// ---------------------------------------------------------
// Sign injection datapath
// SGNJ, SGNJN, SGNJX and passthrough of operand A
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_sign_inject (
  input  noncomp_pkg::fp_t        operand_a_i,
  input  noncomp_pkg::fp_t        operand_b_i,
  input  noncomp_pkg::roundmode_e rnd_mode_i,
  input  logic                    op_mod_i,
  output noncomp_pkg::fp_t        result_o,
  output logic                    ext_o
);

  import noncomp_pkg::*;

  // Exponent and mantissa always come from A, only the sign changes
  always_comb begin
    result_o = operand_a_i;
    unique case (rnd_mode_i)
      // SGNJ takes B's sign
      RNE: result_o.sign = operand_b_i.sign;
      // SGNJN takes the inverse of B's sign
      RTZ: result_o.sign = ~operand_b_i.sign;
      // SGNJX, product of both signs
      RDN: result_o.sign = operand_a_i.sign ^ operand_b_i.sign;
      // Passthrough keeps A as is
      RUP: result_o = operand_a_i;
      default: result_o = operand_a_i;
    endcase
  end

  // Integer extension: sign-extend when op_mod asks for it
  assign ext_o = op_mod_i ? result_o.sign : 1'b1;

endmodule

`default_nettype wire

// ==== design/fp_compare_unit.sv ====
// ---------------------------------------------------------
// Magnitude ordering, min/max and quiet/signalling compares
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_compare_unit (
  input  noncomp_pkg::fp_t        operand_a_i,
  input  noncomp_pkg::fp_t        operand_b_i,
  input  noncomp_pkg::fp_info_t   info_a_i,
  input  noncomp_pkg::fp_info_t   info_b_i,
  input  noncomp_pkg::roundmode_e rnd_mode_i,
  input  logic                    op_mod_i,
  output noncomp_pkg::fp_t        minmax_o,
  output noncomp_pkg::status_t    minmax_status_o,
  output noncomp_pkg::fp_t        cmp_o,
  output noncomp_pkg::status_t    cmp_status_o
);

  import noncomp_pkg::*;

  logic any_nan;
  logic signalling_nan;
  logic operands_equal;
  logic a_smaller;
  logic cmp_bit;

  // ---------------------------------------------------------
  // Shared ordering
  // ---------------------------------------------------------
  assign any_nan        = info_a_i.is_nan | info_b_i.is_nan;
  assign signalling_nan = info_a_i.is_signalling | info_b_i.is_signalling;

  // +0 and -0 count as equal
  assign operands_equal = (operand_a_i == operand_b_i) |
                          (info_a_i.is_zero & info_b_i.is_zero);

  // Sign-magnitude order: unsigned compare, flipped once a sign is set
  assign a_smaller = (operand_a_i < operand_b_i) ^ (operand_a_i.sign | operand_b_i.sign);

  // ---------------------------------------------------------
  // Min / max, RNE = MIN, RTZ = MAX
  // ---------------------------------------------------------
  always_comb begin
    minmax_status_o    = '0;
    // Quiet operation, only sNaN inputs are invalid
    minmax_status_o.NV = signalling_nan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_o = CANON_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_o = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_o = operand_a_i;
    end else if (rnd_mode_i == RTZ) begin
      minmax_o = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      minmax_o = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // ---------------------------------------------------------
  // Comparisons, RNE = LE, RTZ = LT, RDN = EQ
  // ---------------------------------------------------------
  always_comb begin
    cmp_bit      = 1'b0;
    cmp_status_o = '0;
    if (signalling_nan) begin
      // sNaN is invalid for every compare, result stays false
      cmp_status_o.NV = 1'b1;
    end else begin
      unique case (rnd_mode_i)
        RNE: begin
          // LE is a signalling compare, any NaN is invalid
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit = (a_smaller | operands_equal) ^ op_mod_i;
        end
        RTZ: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else cmp_bit = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        RDN: begin
          // Quiet NaN is never equal, no flag raised
          if (any_nan) cmp_bit = op_mod_i;
          else cmp_bit = operands_equal ^ op_mod_i;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // Boolean lands in bit 0 of an integer-style result
  assign cmp_o = fp_t'({{(FP_WIDTH-1){1'b0}}, cmp_bit});

endmodule

`default_nettype wire

// ==== design/noncomp_ctrl.sv ====
// ---------------------------------------------------------
// Result select and output register stage
// Valid/ready handshake with flush and busy indication
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module noncomp_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  noncomp_pkg::op_e          op_i,
  // Datapath results
  input  noncomp_pkg::fp_t          sgnj_i,
  input  logic                      sgnj_ext_i,
  input  noncomp_pkg::fp_t          minmax_i,
  input  noncomp_pkg::status_t      minmax_status_i,
  input  noncomp_pkg::fp_t          cmp_i,
  input  noncomp_pkg::status_t      cmp_status_i,
  input  noncomp_pkg::classmask_e   class_mask_i,
  // Input handshake
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  // Output side
  output noncomp_pkg::noncomp_rsp_t rsp_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  import noncomp_pkg::*;

  noncomp_rsp_t rsp_d;
  noncomp_rsp_t rsp_q;
  logic         valid_q;
  logic         accept;

  // ---------------------------------------------------------
  // Result selection
  // ---------------------------------------------------------
  always_comb begin
    rsp_d = '0;
    // Class mask goes out for every op
    rsp_d.class_mask = class_mask_i;
    unique case (op_i)
      OP_SGNJ: begin
        rsp_d.result        = sgnj_i;
        rsp_d.extension_bit = sgnj_ext_i;
      end
      OP_MINMAX: begin
        rsp_d.result        = minmax_i;
        rsp_d.status        = minmax_status_i;
        // Always a float value
        rsp_d.extension_bit = 1'b1;
      end
      OP_CMP: begin
        rsp_d.result        = cmp_i;
        rsp_d.status        = cmp_status_i;
        rsp_d.extension_bit = 1'b0;
      end
      OP_CLASSIFY: begin
        // Mask only, result and flags stay zero
        rsp_d.is_class = 1'b1;
      end
    endcase
  end

  // ---------------------------------------------------------
  // Output stage
  // ---------------------------------------------------------
  // Stage frees up when the consumer takes it or it holds a bubble
  assign in_ready_o = out_ready_i | ~valid_q;

  // Flush drops whatever arrives this cycle
  assign accept = in_valid_i & in_ready_o & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      rsp_q   <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= 1'b0;
      end else if (in_ready_o) begin
        valid_q <= in_valid_i;
      end
      // Response holds under back-pressure
      if (accept) begin
        rsp_q <= rsp_d;
      end
    end
  end

  assign rsp_o       = rsp_q;
  assign out_valid_o = valid_q;
  // Single stage, so busy is just the stage valid
  assign busy_o      = valid_q;

endmodule

`default_nettype wire

// ==== design/fp_noncomp_top.sv ====
// ---------------------------------------------------------
// FP32 non-computational unit top level
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fp_noncomp_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Request side
  input  noncomp_pkg::noncomp_req_t req_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      flush_i,
  // Response side
  output noncomp_pkg::noncomp_rsp_t rsp_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic                      busy_o
);

  import noncomp_pkg::*;

  fp_info_t   info_a;
  fp_info_t   info_b;
  classmask_e class_mask;
  fp_t        sgnj_result;
  logic       sgnj_ext;
  fp_t        minmax_result;
  status_t    minmax_status;
  fp_t        cmp_result;
  status_t    cmp_status;

  // Operand classification, feeds the compare unit and the mask
  fp_classifier u_classifier (
    .operand_a_i  (req_i.operand_a),
    .operand_b_i  (req_i.operand_b),
    .info_a_o     (info_a),
    .info_b_o     (info_b),
    .class_mask_o (class_mask)
  );

  fp_sign_inject u_sign_inject (
    .operand_a_i (req_i.operand_a),
    .operand_b_i (req_i.operand_b),
    .rnd_mode_i  (req_i.rnd_mode),
    .op_mod_i    (req_i.op_mod),
    .result_o    (sgnj_result),
    .ext_o       (sgnj_ext)
  );

  fp_compare_unit u_compare (
    .operand_a_i     (req_i.operand_a),
    .operand_b_i     (req_i.operand_b),
    .info_a_i        (info_a),
    .info_b_i        (info_b),
    .rnd_mode_i      (req_i.rnd_mode),
    .op_mod_i        (req_i.op_mod),
    .minmax_o        (minmax_result),
    .minmax_status_o (minmax_status),
    .cmp_o           (cmp_result),
    .cmp_status_o    (cmp_status)
  );

  // Select and register, one cycle of latency
  noncomp_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .op_i            (req_i.op),
    .sgnj_i          (sgnj_result),
    .sgnj_ext_i      (sgnj_ext),
    .minmax_i        (minmax_result),
    .minmax_status_i (minmax_status),
    .cmp_i           (cmp_result),
    .cmp_status_i    (cmp_status),
    .class_mask_i    (class_mask),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .flush_i         (flush_i),
    .rsp_o           (rsp_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .busy_o          (busy_o)
  );

endmodule

`default_nettype wire

// ==== tb/noncomp_tests.svh ====
// ---------------------------------------------------------
// Directed tests, one task per behavior
// ---------------------------------------------------------
`ifndef NONCOMP_TESTS_SVH
`define NONCOMP_TESTS_SVH

  task automatic test_reset_state();
    check_eq("reset out_valid", 64'h0, 64'(out_valid));
    check_eq("reset busy", 64'h0, 64'(busy));
    check_eq("reset response", 64'h0, 64'(rsp));
  endtask

  // Result is A with a new sign, extension is the sign only with op_mod
  task automatic test_sign_inject();
    logic [31:0] a;
    logic [31:0] b;
    logic        s;
    logic        ext;
    int          i;
    int          m;
    int          k;
    for (i = 0; i < 8; i++) begin
      a = rand_normal();
      b = rand_normal();
      for (m = 0; m < 4; m++) begin
        case (m)
          0: s = b[31];
          1: s = ~b[31];
          2: s = a[31] ^ b[31];
          default: s = a[31];
        endcase
        for (k = 0; k < 2; k++) begin
          ext = (k == 1) ? s : 1'b1;
          do_op($sformatf("sgnj pair %0d mode %0d mod %0d", i, m, k),
                make_req(OP_SGNJ, a, b, roundmode_e'(m), k[0]),
                build_rsp(a, {s, a[30:0]}, 5'b0, ext));
        end
      end
    end
  endtask

  task automatic minmax_case(input string name, input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] lo, input logic [31:0] hi, input logic nv);
    do_op({name, " min"}, make_req(OP_MINMAX, a, b, RNE, 1'b0),
          build_rsp(a, lo, {nv, 4'b0}, 1'b1));
    do_op({name, " max"}, make_req(OP_MINMAX, a, b, RTZ, 1'b0),
          build_rsp(a, hi, {nv, 4'b0}, 1'b1));
  endtask

  task automatic test_minmax();
    minmax_case("mm 1 2", 32'h3f800000, 32'h40000000, 32'h3f800000, 32'h40000000, 1'b0);
    minmax_case("mm -3 1", 32'hc0400000, 32'h3f800000, 32'hc0400000, 32'h3f800000, 1'b0);
    minmax_case("mm -3 -1", 32'hc0400000, 32'hbf800000, 32'hc0400000, 32'hbf800000, 1'b0);
    // Signed zeros, -0 is the smaller one in either order
    minmax_case("mm -0 +0", 32'h80000000, 32'h00000000, 32'h80000000, 32'h00000000, 1'b0);
    minmax_case("mm +0 -0", 32'h00000000, 32'h80000000, 32'h80000000, 32'h00000000, 1'b0);
    minmax_case("mm qnan 2", 32'h7fc00000, 32'h40000000, 32'h40000000, 32'h40000000, 1'b0);
    minmax_case("mm 2 qnans", 32'h7fc12345, 32'hffc00000, 32'h7fc00000, 32'h7fc00000, 1'b0);
    minmax_case("mm snan 1", 32'h7f800001, 32'h3f800000, 32'h3f800000, 32'h3f800000, 1'b1);
    minmax_case("mm 1 -snan", 32'h3f800000, 32'hff800005, 32'h3f800000, 32'h3f800000, 1'b1);
  endtask

  // Ordered pair, LE = lt|eq, LT = lt, EQ = eq
  task automatic cmp_case(input string name, input logic [31:0] a, input logic [31:0] b,
                          input logic lt, input logic eq);
    logic truth;
    int   m;
    int   k;
    for (m = 0; m < 3; m++) begin
      truth = (m == 0) ? (lt | eq) : ((m == 1) ? lt : eq);
      for (k = 0; k < 2; k++) begin
        do_op($sformatf("%s mode %0d mod %0d", name, m, k),
              make_req(OP_CMP, a, b, roundmode_e'(m), k[0]),
              build_rsp(a, {31'b0, truth ^ k[0]}, 5'b0, 1'b0));
      end
    end
  endtask

  // Quiet NaN: LE and LT invalid, EQ gives op_mod; sNaN: 0 with NV
  task automatic nan_cmp_case(input string name, input logic [31:0] a, input logic [31:0] b,
                              input logic signalling);
    int m;
    int k;
    for (m = 0; m < 3; m++) begin
      for (k = 0; k < 2; k++) begin
        if (!signalling && m == 2) begin
          do_op($sformatf("%s mode %0d mod %0d", name, m, k),
                make_req(OP_CMP, a, b, roundmode_e'(m), k[0]),
                build_rsp(a, {31'b0, k[0]}, 5'b0, 1'b0));
        end else begin
          do_op($sformatf("%s mode %0d mod %0d", name, m, k),
                make_req(OP_CMP, a, b, roundmode_e'(m), k[0]),
                build_rsp(a, 32'h0, 5'b10000, 1'b0));
        end
      end
    end
  endtask

  task automatic test_compare();
    cmp_case("cmp 1 2", 32'h3f800000, 32'h40000000, 1'b1, 1'b0);
    cmp_case("cmp 2 1", 32'h40000000, 32'h3f800000, 1'b0, 1'b0);
    cmp_case("cmp -3 1", 32'hc0400000, 32'h3f800000, 1'b1, 1'b0);
    cmp_case("cmp -3 -1", 32'hc0400000, 32'hbf800000, 1'b1, 1'b0);
    cmp_case("cmp 1 1", 32'h3f800000, 32'h3f800000, 1'b0, 1'b1);
    cmp_case("cmp -0 +0", 32'h80000000, 32'h00000000, 1'b0, 1'b1);
    nan_cmp_case("cmp qnan a", 32'h7fc00000, 32'h3f800000, 1'b0);
    nan_cmp_case("cmp qnan b", 32'h3f800000, 32'hffc00001, 1'b0);
    nan_cmp_case("cmp snan", 32'h7f800001, 32'h3f800000, 1'b1);
  endtask

  // Samples listed in fclass bit order
  task automatic test_classify();
    logic [31:0]  vals [10];
    noncomp_rsp_t expected;
    int           i;
    vals = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
             32'h007fffff, 32'h3f800000, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
    for (i = 0; i < 10; i++) begin
      expected            = '0;
      expected.class_mask = classmask_e'(10'b1 << i);
      expected.is_class   = 1'b1;
      do_op($sformatf("classify %0d", i),
            make_req(OP_CLASSIFY, vals[i], rand_normal(), RNE, 1'b0), expected);
    end
  endtask

  task automatic test_backpressure();
    noncomp_rsp_t held;
    int unsigned  lat;
    int           i;
    @(negedge clk);
    out_ready = 1'b0;
    send_req(make_req(OP_SGNJ, 32'h3f800000, 32'hc0000000, RNE, 1'b0));
    wait_out(lat);
    held = rsp;
    check_eq("bp first", 64'(build_rsp(32'h3f800000, 32'hbf800000, 5'b0, 1'b1)), 64'(held));
    // Next request waits while the stage is blocked
    req      = make_req(OP_MINMAX, 32'h40400000, 32'h40800000, RNE, 1'b0);
    in_valid = 1'b1;
    for (i = 0; i < 5; i++) begin
      @(negedge clk);
      check_eq("bp out_valid", 64'h1, 64'(out_valid));
      check_eq("bp busy", 64'h1, 64'(busy));
      check_eq("bp hold", 64'(held), 64'(rsp));
      check_eq("bp in_ready", 64'h0, 64'(in_ready));
    end
    out_ready = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    check_eq("bp second valid", 64'h1, 64'(out_valid));
    check_eq("bp second", 64'(build_rsp(32'h40400000, 32'h40400000, 5'b0, 1'b1)), 64'(rsp));
  endtask

  task automatic test_flush();
    int unsigned lat;
    // Request and flush in the same cycle, nothing gets through
    @(negedge clk);
    req      = make_req(OP_SGNJ, 32'h3f800000, 32'h40000000, RNE, 1'b0);
    in_valid = 1'b1;
    flush    = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    flush    = 1'b0;
    expect_no_out("flush new");
    // Flush of a response held under back-pressure
    out_ready = 1'b0;
    send_req(make_req(OP_CMP, 32'h3f800000, 32'h40000000, RNE, 1'b0));
    wait_out(lat);
    flush = 1'b1;
    @(negedge clk);
    flush     = 1'b0;
    out_ready = 1'b1;
    check_eq("flush held valid", 64'h0, 64'(out_valid));
    check_eq("flush held busy", 64'h0, 64'(busy));
  endtask

`endif

// ==== tb/tb_noncomp.sv ====
// ---------------------------------------------------------
// Testbench for the FP32 non-computational unit
// Directed tests through the valid/ready interface
// ---------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_noncomp;

  import noncomp_pkg::*;

  // Cycle limit of every wait loop
  localparam int unsigned WAIT_LIMIT = 20;
  localparam logic [31:0] SEED       = 32'hfbb2daaa;

  logic         clk;
  logic         rst_n;
  noncomp_req_t req;
  logic         in_valid;
  logic         in_ready;
  logic         flush;
  noncomp_rsp_t rsp;
  logic         out_valid;
  logic         out_ready;
  logic         busy;

  fp_noncomp_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .flush_i     (flush),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ---------------------------------------------------------
  // Reporting
  // ---------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped after the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // ---------------------------------------------------------
  // Reference helpers
  // ---------------------------------------------------------
  // Random normal FP32 word, exponent kept in 1..254
  function automatic logic [31:0] rand_normal();
    logic [31:0] r;
    logic [7:0]  e;
    r = $urandom();
    e = 8'(1 + ($urandom() % 254));
    return {r[31], e, r[22:0]};
  endfunction

  // Expected fclass bit of a raw FP32 word
  function automatic logic [9:0] class_of(input logic [31:0] v);
    if (v[30:23] == 8'hff) begin
      if (v[22:0] == '0) return v[31] ? 10'h001 : 10'h080;
      // Quiet bit set means qNaN
      return v[22] ? 10'h200 : 10'h100;
    end
    if (v[30:23] != 8'h00) return v[31] ? 10'h002 : 10'h040;
    if (v[22:0] != '0) return v[31] ? 10'h004 : 10'h020;
    return v[31] ? 10'h008 : 10'h010;
  endfunction

  function automatic noncomp_req_t make_req(input op_e op, input logic [31:0] a,
                                            input logic [31:0] b, input roundmode_e mode,
                                            input logic op_mod);
    noncomp_req_t r;
    r.operand_a = fp_t'(a);
    r.operand_b = fp_t'(b);
    r.rnd_mode  = mode;
    r.op        = op;
    r.op_mod    = op_mod;
    return r;
  endfunction

  // Class mask always follows operand A
  function automatic noncomp_rsp_t build_rsp(input logic [31:0] a, input logic [31:0] result,
                                             input logic [4:0] status, input logic ext);
    noncomp_rsp_t r;
    r.result        = fp_t'(result);
    r.status        = status_t'(status);
    r.extension_bit = ext;
    r.class_mask    = classmask_e'(class_of(a));
    r.is_class      = 1'b0;
    return r;
  endfunction

  // ---------------------------------------------------------
  // Drive and wait
  // ---------------------------------------------------------
  // in_ready only moves on rising edges, so it is stable at the falling edge
  task automatic send_req(input noncomp_req_t item);
    int unsigned cycles;
    @(negedge clk);
    req      = item;
    in_valid = 1'b1;
    cycles   = 0;
    while (!in_ready) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: the request was never accepted, in_ready_o stayed low");
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_out(output int unsigned cycles);
    cycles = 0;
    while (!out_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: no response showed up on out_valid_o");
      end
    end
  endtask

  // A flushed item must never appear, so this wait runs out on purpose
  task automatic expect_no_out(input string name);
    int unsigned cycles;
    cycles = 0;
    while (cycles < WAIT_LIMIT) begin
      if (out_valid) begin
        abort_run({name, ": out_valid_o rose for a flushed request"});
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // One request, one response, checked whole
  task automatic do_op(input string name, input noncomp_req_t item,
                       input noncomp_rsp_t expected);
    int unsigned lat;
    send_req(item);
    wait_out(lat);
    // Accepted on the edge just passed, response must already be there
    check_eq({name, " latency"}, 64'h0, 64'(lat));
    check_eq(name, 64'(expected), 64'(rsp));
  endtask

  `include "noncomp_tests.svh"

  // ---------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------
  initial begin
    rst_n      = 1'b0;
    req        = '0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    out_ready  = 1'b1;
    void'($urandom(SEED));
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_sign_inject();
    test_minmax();
    test_compare();
    test_classify();
    test_backpressure();
    test_flush();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tb
design/noncomp_pkg.sv
design/fp_classifier.sv
design/fp_sign_inject.sv
design/fp_compare_unit.sv
design/noncomp_ctrl.sv
design/fp_noncomp_top.sv
tb/tb_noncomp.sv

// ==== Makefile ====
# Verilator build and run of the FP32 non-computational unit testbench

SIM      ?= verilator
SIMFLAGS ?= --binary --timing
TOP      ?= tb_noncomp
FILELIST ?= sim.f
OBJDIR   ?= obj_dir

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
